// File: common/alu_pkg.sv
/*
 * Shared ALU definitions: data and shift widths, the operator encoding,
 * the request bundle, result and branch selectors and the decoded control
 */

package alu_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------
    localparam int unsigned XLEN         = 64;
    localparam int unsigned WORD_W       = 32;
    localparam int unsigned SHAMT_W      = 6;
    localparam int unsigned SHAMT_W_WORD = 5;

    typedef logic [XLEN-1:0] xlen_t;

    // ------------------------------------------------------------------------
    // Operator encoding
    // ------------------------------------------------------------------------
    typedef enum logic [4:0] {
        // Adder
        ADD, SUB, ADDW, SUBW,
        // Shifter
        SLL, SRL, SRA, SLLW, SRLW, SRAW,
        // Logical
        ANDL, ORL, XORL,
        // Set less than
        SLTS, SLTU,
        // Branch conditions
        EQ, NE, LTS, LTU, GES, GEU
    } alu_op_e;

    // One request as issued to the execute stage
    typedef struct packed {
        alu_op_e op;
        xlen_t   operand_a;
        xlen_t   operand_b;
    } alu_req_t;

    // ------------------------------------------------------------------------
    // Decoded control
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        RES_ADD,
        RES_ADDW,
        RES_SHIFT,
        RES_SHIFTW,
        RES_AND,
        RES_OR,
        RES_XOR,
        RES_LESS
    } alu_res_sel_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE
    } alu_br_e;

    typedef struct packed {
        logic         negate_b;     // adder computes a - b
        logic         shift_left;
        logic         shift_arith;
        logic         signed_cmp;
        alu_res_sel_e res_sel;
        alu_br_e      br_cond;
    } alu_ctrl_t;

endpackage

// File: rtl/alu_decoder.sv
/*
 * Operator decoder
 * Turns the operator code into the control struct of the datapath
 */

`timescale 1ns/1ps

module alu_decoder import alu_pkg::*; (
    input  alu_op_e   op_i,
    output alu_ctrl_t ctrl_o
);

    always_comb begin
        // Defaults also cover unused operator codes
        ctrl_o             = '0;
        ctrl_o.res_sel     = RES_AND;
        ctrl_o.br_cond     = BR_NONE;

        case (op_i)
            // Adder
            ADD:  ctrl_o.res_sel = RES_ADD;
            SUB: begin
                ctrl_o.negate_b = 1'b1;
                ctrl_o.res_sel  = RES_ADD;
            end
            ADDW: ctrl_o.res_sel = RES_ADDW;
            SUBW: begin
                ctrl_o.negate_b = 1'b1;
                ctrl_o.res_sel  = RES_ADDW;
            end

            // Shifts
            SLL: begin
                ctrl_o.shift_left = 1'b1;
                ctrl_o.res_sel    = RES_SHIFT;
            end
            SRL:  ctrl_o.res_sel = RES_SHIFT;
            SRA: begin
                ctrl_o.shift_arith = 1'b1;
                ctrl_o.res_sel     = RES_SHIFT;
            end
            SLLW: begin
                ctrl_o.shift_left = 1'b1;
                ctrl_o.res_sel    = RES_SHIFTW;
            end
            SRLW: ctrl_o.res_sel = RES_SHIFTW;
            SRAW: begin
                ctrl_o.shift_arith = 1'b1;
                ctrl_o.res_sel     = RES_SHIFTW;
            end

            // Logical and set-less-than
            ANDL: ctrl_o.res_sel = RES_AND;
            ORL:  ctrl_o.res_sel = RES_OR;
            XORL: ctrl_o.res_sel = RES_XOR;
            SLTS: begin
                ctrl_o.signed_cmp = 1'b1;
                ctrl_o.res_sel    = RES_LESS;
            end
            SLTU: ctrl_o.res_sel = RES_LESS;

            // Branches, equality ones return the difference a - b
            EQ, NE: begin
                ctrl_o.negate_b = 1'b1;
                ctrl_o.res_sel  = RES_ADD;
                ctrl_o.br_cond  = (op_i == EQ) ? BR_EQ : BR_NE;
            end
            // Ordered ones return the less flag
            LTS, GES: begin
                ctrl_o.signed_cmp = 1'b1;
                ctrl_o.res_sel    = RES_LESS;
                ctrl_o.br_cond    = (op_i == LTS) ? BR_LT : BR_GE;
            end
            LTU, GEU: begin
                ctrl_o.res_sel = RES_LESS;
                ctrl_o.br_cond = (op_i == LTU) ? BR_LT : BR_GE;
            end

            default: ;
        endcase
    end

endmodule

// File: rtl/alu_adder.sv
/*
 * Shared adder for add, subtract and equality compare
 * Zero flag on the result
 */

`timescale 1ns/1ps

module alu_adder import alu_pkg::*; (
    input  xlen_t operand_a_i,
    input  xlen_t operand_b_i,
    input  logic  negate_b_i,
    output xlen_t result_o,
    output logic  zero_o
);

    logic [XLEN:0]   adder_in_a;
    logic [XLEN:0]   adder_in_b;
    logic [XLEN+1:0] adder_sum;

    // ------------------------------------------------------------------------
    // Carry-in folded into bit 0
    // ------------------------------------------------------------------------
    // Operand a gets a constant 1 below its LSB. Operand b gets a 0 there,
    // which the inversion turns into 1 when subtracting, so the low
    // position produces the +1 of the two's complement.
    assign adder_in_a = {operand_a_i, 1'b1};
    assign adder_in_b = {operand_b_i, 1'b0} ^ {(XLEN+1){negate_b_i}};

    assign adder_sum = {1'b0, adder_in_a} + {1'b0, adder_in_b};

    // Drop the helper bit
    assign result_o = adder_sum[XLEN:1];

    // Difference of zero means a == b
    assign zero_o = ~|adder_sum[XLEN:1];

endmodule

// File: shifter/alu_shifter.sv
/*
 * Barrel shifter, full width and 32-bit word width in parallel
 * Left shifts go through the right shifter with bit reversal
 */

`timescale 1ns/1ps

module alu_shifter import alu_pkg::*; (
    input  xlen_t              operand_i,
    input  logic [SHAMT_W-1:0] shamt_i,
    input  logic               shift_left_i,
    input  logic               shift_arith_i,
    output xlen_t              result_o,
    output logic [WORD_W-1:0]  result_word_o
);

    xlen_t             operand_rev;
    logic [WORD_W-1:0] operand_rev_word;
    xlen_t             shift_in;
    logic [WORD_W-1:0] shift_in_word;
    logic [XLEN:0]     shift_in_ext;
    logic [WORD_W:0]   shift_in_word_ext;
    logic [XLEN:0]     right_result;
    logic [WORD_W:0]   right_result_word;
    xlen_t             left_result;
    logic [WORD_W-1:0] left_result_word;

    // ------------------------------------------------------------------------
    // Bit reversal on the way in and out
    // ------------------------------------------------------------------------
    for (genvar k = 0; k < XLEN; k++) begin : g_rev
        assign operand_rev[k] = operand_i[XLEN-1-k];
        assign left_result[k] = right_result[XLEN-1-k];
    end

    for (genvar k = 0; k < WORD_W; k++) begin : g_rev_word
        assign operand_rev_word[k] = operand_i[WORD_W-1-k];
        assign left_result_word[k] = right_result_word[WORD_W-1-k];
    end

    assign shift_in      = shift_left_i ? operand_rev : operand_i;
    assign shift_in_word = shift_left_i ? operand_rev_word : operand_i[WORD_W-1:0];

    // ------------------------------------------------------------------------
    // Right shifters
    // ------------------------------------------------------------------------
    // Extra top bit carries the sign for arithmetic shifts, zero otherwise
    assign shift_in_ext      = {shift_arith_i & shift_in[XLEN-1], shift_in};
    assign shift_in_word_ext = {shift_arith_i & shift_in_word[WORD_W-1], shift_in_word};

    assign right_result = $unsigned($signed(shift_in_ext) >>> shamt_i);

    // Word shifts only see the low 5 amount bits
    assign right_result_word =
        $unsigned($signed(shift_in_word_ext) >>> shamt_i[SHAMT_W_WORD-1:0]);

    assign result_o      = shift_left_i ? left_result : right_result[XLEN-1:0];
    assign result_word_o = shift_left_i ? left_result_word : right_result_word[WORD_W-1:0];

endmodule

// File: rtl/alu_compare.sv
/*
 * Signed or unsigned less-than and branch condition resolution
 */

`timescale 1ns/1ps

module alu_compare import alu_pkg::*; (
    input  xlen_t   operand_a_i,
    input  xlen_t   operand_b_i,
    input  logic    signed_i,
    input  alu_br_e br_cond_i,
    input  logic    adder_zero_i,
    output logic    less_o,
    output logic    branch_taken_o
);

    logic [XLEN:0] cmp_a;
    logic [XLEN:0] cmp_b;

    // One extra bit, sign-filled only for signed compares
    assign cmp_a = {signed_i & operand_a_i[XLEN-1], operand_a_i};
    assign cmp_b = {signed_i & operand_b_i[XLEN-1], operand_b_i};

    assign less_o = $signed(cmp_a) < $signed(cmp_b);

    always_comb begin
        case (br_cond_i)
            BR_EQ:   branch_taken_o = adder_zero_i;
            BR_NE:   branch_taken_o = ~adder_zero_i;
            BR_LT:   branch_taken_o = less_o;
            BR_GE:   branch_taken_o = ~less_o;
            // Non-branch operators report taken
            default: branch_taken_o = 1'b1;
        endcase
    end

endmodule

// File: rtl/alu_result_sel.sv
/*
 * Logical operations, result multiplexer and the output register stage
 */

`timescale 1ns/1ps

module alu_result_sel import alu_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  xlen_t             operand_a_i,
    input  xlen_t             operand_b_i,
    input  alu_res_sel_e      res_sel_i,
    input  xlen_t             adder_result_i,
    input  xlen_t             shift_result_i,
    input  logic [WORD_W-1:0] shift_result_word_i,
    input  logic              less_i,
    input  logic              branch_taken_i,
    input  logic              valid_i,
    output xlen_t             result_o,
    output logic              branch_taken_o,
    output logic              valid_o
);

    xlen_t adder_word_ext;
    xlen_t shift_word_ext;
    xlen_t result_d;
    xlen_t result_q;
    logic  branch_taken_q;
    logic  valid_q;

    // Word results are sign-extended from bit 31
    assign adder_word_ext = {{(XLEN-WORD_W){adder_result_i[WORD_W-1]}},
                             adder_result_i[WORD_W-1:0]};
    assign shift_word_ext = {{(XLEN-WORD_W){shift_result_word_i[WORD_W-1]}},
                             shift_result_word_i};

    // ------------------------------------------------------------------------
    // Result mux
    // ------------------------------------------------------------------------
    always_comb begin
        result_d = '0;
        case (res_sel_i)
            RES_ADD:    result_d = adder_result_i;
            RES_ADDW:   result_d = adder_word_ext;
            RES_SHIFT:  result_d = shift_result_i;
            RES_SHIFTW: result_d = shift_word_ext;
            RES_AND:    result_d = operand_a_i & operand_b_i;
            RES_OR:     result_d = operand_a_i | operand_b_i;
            RES_XOR:    result_d = operand_a_i ^ operand_b_i;
            RES_LESS:   result_d = {{(XLEN-1){1'b0}}, less_i};
            default:    result_d = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Output stage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            result_q       <= '0;
            branch_taken_q <= 1'b0;
            valid_q        <= 1'b0;
        end else begin
            valid_q <= valid_i;
            // Hold the last result through idle cycles
            if (valid_i) begin
                result_q       <= result_d;
                branch_taken_q <= branch_taken_i;
            end
        end
    end

    assign result_o       = result_q;
    assign branch_taken_o = branch_taken_q;
    assign valid_o        = valid_q;

endmodule

// File: rtl/alu_top.sv
/*
 * ALU execute stage top level
 * Operator decoder, adder, shifter, comparator and result register
 */

`timescale 1ns/1ps

module alu_top import alu_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  alu_req_t req_i,
    input  logic     valid_i,
    output xlen_t    result_o,
    output logic     branch_taken_o,
    output logic     valid_o
);

    alu_ctrl_t          ctrl;
    xlen_t              adder_result;
    logic               adder_zero;
    xlen_t              shift_result;
    logic [WORD_W-1:0]  shift_result_word;
    logic               less;
    logic               branch_taken;

    // Only the decoder looks at the operator
    alu_decoder i_alu_decoder (
        .op_i   (req_i.op),
        .ctrl_o (ctrl)
    );

    alu_adder i_alu_adder (
        .operand_a_i (req_i.operand_a),
        .operand_b_i (req_i.operand_b),
        .negate_b_i  (ctrl.negate_b),
        .result_o    (adder_result),
        .zero_o      (adder_zero)
    );

    // Shift amount is the low bits of operand b
    alu_shifter i_alu_shifter (
        .operand_i     (req_i.operand_a),
        .shamt_i       (req_i.operand_b[SHAMT_W-1:0]),
        .shift_left_i  (ctrl.shift_left),
        .shift_arith_i (ctrl.shift_arith),
        .result_o      (shift_result),
        .result_word_o (shift_result_word)
    );

    alu_compare i_alu_compare (
        .operand_a_i    (req_i.operand_a),
        .operand_b_i    (req_i.operand_b),
        .signed_i       (ctrl.signed_cmp),
        .br_cond_i      (ctrl.br_cond),
        .adder_zero_i   (adder_zero),
        .less_o         (less),
        .branch_taken_o (branch_taken)
    );

    // Result mux and the single register stage
    alu_result_sel i_alu_result_sel (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .operand_a_i         (req_i.operand_a),
        .operand_b_i         (req_i.operand_b),
        .res_sel_i           (ctrl.res_sel),
        .adder_result_i      (adder_result),
        .shift_result_i      (shift_result),
        .shift_result_word_i (shift_result_word),
        .less_i              (less),
        .branch_taken_i      (branch_taken),
        .valid_i             (valid_i),
        .result_o            (result_o),
        .branch_taken_o      (branch_taken_o),
        .valid_o             (valid_o)
    );

endmodule

// File: bench/alu_ref.svh
/*
 * Reference model of the ALU execute stage
 * Expected result word and branch outcome for one request
 */

`ifndef ALU_REF_SVH
`define ALU_REF_SVH

typedef struct packed {
    xlen_t result;
    logic  taken;
} ref_out_t;

function automatic xlen_t sign_extend_word(input logic [31:0] w);
    return {{32{w[31]}}, w};
endfunction

function automatic ref_out_t alu_ref_model(input alu_req_t req);
    ref_out_t    r;
    xlen_t       a;
    xlen_t       b;
    logic [31:0] w;
    logic        lts;
    logic        ltu;

    a   = req.operand_a;
    b   = req.operand_b;
    lts = $signed(a) < $signed(b);
    ltu = a < b;
    w   = '0;
    // Non-branch operators report taken
    r.taken  = 1'b1;
    r.result = '0;

    case (req.op)
        ADD:  r.result = a + b;
        SUB:  r.result = a - b;
        ADDW: begin
            w        = a[31:0] + b[31:0];
            r.result = sign_extend_word(w);
        end
        SUBW: begin
            w        = a[31:0] - b[31:0];
            r.result = sign_extend_word(w);
        end
        SLL:  r.result = a << b[5:0];
        SRL:  r.result = a >> b[5:0];
        SRA:  r.result = $signed(a) >>> b[5:0];
        SLLW: begin
            w        = a[31:0] << b[4:0];
            r.result = sign_extend_word(w);
        end
        SRLW: begin
            w        = a[31:0] >> b[4:0];
            r.result = sign_extend_word(w);
        end
        SRAW: begin
            w        = $signed(a[31:0]) >>> b[4:0];
            r.result = sign_extend_word(w);
        end
        ANDL: r.result = a & b;
        ORL:  r.result = a | b;
        XORL: r.result = a ^ b;
        SLTS: r.result = {{(XLEN-1){1'b0}}, lts};
        SLTU: r.result = {{(XLEN-1){1'b0}}, ltu};
        // Equality branches return the difference, ordered ones the less flag
        EQ: begin
            r.result = a - b;
            r.taken  = (a == b);
        end
        NE: begin
            r.result = a - b;
            r.taken  = (a != b);
        end
        LTS: begin
            r.result = {{(XLEN-1){1'b0}}, lts};
            r.taken  = lts;
        end
        GES: begin
            r.result = {{(XLEN-1){1'b0}}, lts};
            r.taken  = ~lts;
        end
        LTU: begin
            r.result = {{(XLEN-1){1'b0}}, ltu};
            r.taken  = ltu;
        end
        GEU: begin
            r.result = {{(XLEN-1){1'b0}}, ltu};
            r.taken  = ~ltu;
        end
        default: r.result = a & b;
    endcase
    return r;
endfunction

`endif

// File: bench/alu_tb.sv
/*
 * ALU execute stage testbench
 * Directed and random requests, reference compare, latency and hold checks
 */

`timescale 1ns/1ps

module alu_tb import alu_pkg::*; ();

    localparam int unsigned DRAIN_LIMIT = 16;

    // One expected response and the cycle it is due on
    typedef struct packed {
        alu_op_e     op;
        xlen_t       result;
        logic        taken;
        logic [31:0] due;
    } exp_t;

    logic        clk_i;
    logic        rst_n_i;
    alu_req_t    req_i;
    logic        valid_i;
    xlen_t       result_o;
    logic        branch_taken_o;
    logic        valid_o;

    integer      seed;
    int unsigned cycle_cnt;
    int unsigned check_cnt;
    int unsigned err_cnt;
    int unsigned test_err_base;
    int unsigned tests_passed;
    int unsigned tests_failed;
    exp_t        exp_q [$];
    xlen_t       last_result;
    logic        last_taken;

    // Adder corners for overflow, the word sign bit and zero results
    xlen_t corner_a [6] = '{64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000,
                            64'h0000_0000_7fff_ffff, 64'h0, 64'h1234_5678_0000_0001,
                            64'hffff_ffff_ffff_ffff};
    xlen_t corner_b [6] = '{64'h1, 64'h1, 64'h1, 64'h1, 64'hffff_ffff_ffff_ffff,
                            64'hffff_ffff_ffff_ffff};
    int unsigned shamts [6] = '{0, 1, 31, 32, 63, 45};

    `include "alu_ref.svh"

    alu_top i_alu_top (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_i          (req_i),
        .valid_i        (valid_i),
        .result_o       (result_o),
        .branch_taken_o (branch_taken_o),
        .valid_o        (valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    function automatic xlen_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic drive_req(input alu_op_e op, input xlen_t a, input xlen_t b);
        exp_t     e;
        ref_out_t r;
        @(posedge clk_i);
        #2;
        req_i.op        = op;
        req_i.operand_a = a;
        req_i.operand_b = b;
        valid_i         = 1'b1;
        r        = alu_ref_model(req_i);
        e.op     = op;
        e.result = r.result;
        e.taken  = r.taken;
        e.due    = cycle_cnt + 1;
        exp_q.push_back(e);
    endtask

    // Idle cycle with fresh operands so that held outputs are exercised
    task automatic drive_idle();
        @(posedge clk_i);
        #2;
        valid_i         = 1'b0;
        req_i.operand_a = rand_word();
        req_i.operand_b = rand_word();
    endtask

    task automatic finish_test(input string name);
        int unsigned waited;
        waited = 0;
        drive_idle();
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            drive_idle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d results never arrived in test %s", exp_q.size(), name);
            err_cnt++;
            exp_q.delete();
        end
        if (err_cnt == test_err_base)
            tests_passed++;
        else
            tests_failed++;
        $display("test %s done, %0d errors", name, err_cnt - test_err_base);
        test_err_base = err_cnt;
    endtask

    // ------------------------------------------------------------------------
    // Compare process on the falling edge where outputs are stable
    // ------------------------------------------------------------------------
    always @(negedge clk_i) begin : compare_proc
        exp_t e;
        if (rst_n_i === 1'b1) begin
            check_cnt++;
            if (exp_q.size() != 0 && exp_q[0].due == cycle_cnt) begin
                e = exp_q.pop_front();
                if (valid_o !== 1'b1) begin
                    $display("mismatch valid_o op %0d expected %h got %h", e.op, 1'b1, valid_o);
                    err_cnt++;
                end
                if (result_o !== e.result) begin
                    $display("mismatch result_o op %0d expected %h got %h",
                             e.op, e.result, result_o);
                    err_cnt++;
                end
                if (branch_taken_o !== e.taken) begin
                    $display("mismatch branch_taken_o op %0d expected %h got %h",
                             e.op, e.taken, branch_taken_o);
                    err_cnt++;
                end
                last_result = e.result;
                last_taken  = e.taken;
            end else begin
                if (valid_o !== 1'b0) begin
                    $display("mismatch valid_o expected %h got %h", 1'b0, valid_o);
                    err_cnt++;
                end
                if (result_o !== last_result) begin
                    $display("mismatch result_o held expected %h got %h", last_result, result_o);
                    err_cnt++;
                end
                if (branch_taken_o !== last_taken) begin
                    $display("mismatch branch_taken_o held expected %h got %h",
                             last_taken, branch_taken_o);
                    err_cnt++;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin : main_seq
        xlen_t a;
        xlen_t b;
        seed          = 32'hab6edbc8;
        rst_n_i       = 1'b0;
        valid_i       = 1'b0;
        req_i         = '0;
        cycle_cnt     = 0;
        check_cnt     = 0;
        err_cnt       = 0;
        test_err_base = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        last_result   = '0;
        last_taken    = 1'b0;

        repeat (16) begin
            @(posedge clk_i);
            #2;
            check_cnt++;
            if (valid_o !== 1'b0) begin
                $display("mismatch valid_o in reset expected %h got %h", 1'b0, valid_o);
                err_cnt++;
            end
            if (result_o !== '0) begin
                $display("mismatch result_o in reset expected %h got %h", 64'h0, result_o);
                err_cnt++;
            end
            if (branch_taken_o !== 1'b0) begin
                $display("mismatch branch_taken_o in reset expected %h got %h",
                         1'b0, branch_taken_o);
                err_cnt++;
            end
        end
        rst_n_i = 1'b1;
        finish_test("reset");

        for (int i = 0; i < 6; i++)
            for (int k = 0; k < 4; k++)
                drive_req(alu_op_e'(k), corner_a[i], corner_b[i]);
        repeat (200) begin
            a = rand_word();
            b = rand_word();
            for (int k = 0; k < 4; k++)
                drive_req(alu_op_e'(k), a, b);
        end
        finish_test("adder");

        // Fixed amounts on operands with both sign bits set
        for (int i = 0; i < 6; i++) begin
            for (int k = SLL; k <= SRAW; k++) begin
                a     = rand_word();
                a[63] = 1'b1;
                a[31] = 1'b1;
                b     = rand_word();
                b[5:0] = shamts[i];
                drive_req(alu_op_e'(k), a, b);
            end
        end
        repeat (40)
            for (int k = SLL; k <= SRAW; k++)
                drive_req(alu_op_e'(k), rand_word(), rand_word());
        finish_test("shift");

        repeat (100)
            for (int k = ANDL; k <= SLTU; k++)
                drive_req(alu_op_e'(k), rand_word(), rand_word());
        // Pairs that differ only in the sign bit
        repeat (10) begin
            a     = rand_word();
            a[63] = 1'b0;
            b     = a;
            b[63] = 1'b1;
            for (int k = ANDL; k <= SLTU; k++) begin
                drive_req(alu_op_e'(k), a, b);
                drive_req(alu_op_e'(k), b, a);
            end
        end
        finish_test("logic_slt");

        repeat (10) begin
            a     = rand_word();
            a[63] = 1'b1;
            b     = rand_word();
            b[63] = 1'b0;
            for (int k = EQ; k <= GEU; k++) begin
                drive_req(alu_op_e'(k), a, a);
                drive_req(alu_op_e'(k), a, b);
                drive_req(alu_op_e'(k), b, a);
                drive_req(alu_op_e'(k), b >> 1, (b >> 1) + 1);
            end
        end
        finish_test("branch");

        repeat (30)
            drive_req(alu_op_e'($unsigned($random(seed)) % 21), rand_word(), rand_word());
        for (int i = 0; i < 30; i++) begin
            if (i % 3 == 2)
                drive_idle();
            else
                drive_req(alu_op_e'($unsigned($random(seed)) % 21), rand_word(), rand_word());
        end
        finish_test("latency");

        $display("tests passed %0d failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, check_cnt, err_cnt);
        if (err_cnt == 0 && tests_failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: alu.f
+incdir+bench
common/alu_pkg.sv
rtl/alu_decoder.sv
rtl/alu_adder.sv
shifter/alu_shifter.sv
rtl/alu_compare.sv
rtl/alu_result_sel.sv
rtl/alu_top.sv
bench/alu_tb.sv
